/* src/ke_pkg.sv */
`default_nettype none

package ke_pkg;

    // container geometry
    localparam int w6b = 48;
    localparam int w4b = 32;
    localparam int w2b = 16;
    localparam int n_cont = 8;
    localparam int n_stages = 5;
    localparam int meta_w = 256;

    // tenant index lives inside the metadata
    localparam int tenant_lsb = 133;
    localparam int tbl_aw = 4;
    localparam int table_depth = 16;

    localparam int key_w = 2 * w6b + 2 * w4b + 2 * w2b + n_stages;
    localparam int off_w = 18;

    // comparator codes
    localparam logic [1:0] cmp_gt = 2'b00;
    localparam logic [1:0] cmp_ge = 2'b01;
    localparam logic [1:0] cmp_eq = 2'b10;
    localparam logic [1:0] cmp_true = 2'b11;

    // container width codes, 11 reads as zero
    localparam logic [1:0] sel_2b = 2'b00;
    localparam logic [1:0] sel_4b = 2'b01;
    localparam logic [1:0] sel_6b = 2'b10;

    typedef struct packed {
        logic [2:0] spare;
        logic [1:0] width;
        logic [2:0] index;
    } cont_ref_t;

    // operand byte, either a literal or a container reference
    typedef union packed {
        logic [7:0] imm;
        cont_ref_t cref;
    } operand_u;

    typedef struct packed {
        logic is_imm;
        operand_u val;
    } operand_t;

    typedef struct packed {
        logic [1:0] code;
        operand_t a;
        operand_t b;
    } cmp_op_t;

    // stage 0 opcode sits at the top of the opcode field
    typedef struct packed {
        logic [n_cont-1:0][w6b-1:0] c6;
        logic [n_cont-1:0][w4b-1:0] c4;
        logic [n_cont-1:0][w2b-1:0] c2;
        cmp_op_t [0:n_stages-1] ops;
        logic [meta_w-1:0] meta;
    } phv_t;

    typedef struct packed {
        logic [2:0] c6_a;
        logic [2:0] c6_b;
        logic [2:0] c4_a;
        logic [2:0] c4_b;
        logic [2:0] c2_a;
        logic [2:0] c2_b;
    } key_offset_t;

    typedef struct packed {
        logic [w6b-1:0] c6_a;
        logic [w6b-1:0] c6_b;
        logic [w4b-1:0] c4_a;
        logic [w4b-1:0] c4_b;
        logic [w2b-1:0] c2_a;
        logic [w2b-1:0] c2_b;
        logic [n_stages-1:0] cmp;
    } key_t;

    // sel 0 = offset table, 1 = mask table
    typedef struct packed {
        logic strobe;
        logic sel;
        logic [tbl_aw-1:0] index;
        logic [key_w-1:0] data;
    } cfg_wr_t;

    typedef struct packed {
        phv_t phv;
        key_offset_t offset;
        key_t mask;
    } lk_bus_t;

    typedef struct packed {
        phv_t phv;
        key_offset_t offset;
        key_t mask;
        logic cmp_bit;
    } op_bus_t;

endpackage

`default_nettype wire

/* src/ke_config_table.sv */
`timescale 1ns/10ps
`default_nettype none

module ke_config_table #(
    parameter int width = 18,
    parameter logic table_sel = 1'b0
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire ke_pkg::cfg_wr_t           cfg,
    input  wire logic                      rd_en,
    input  wire logic [ke_pkg::tbl_aw-1:0] rd_index,
    output logic [width-1:0]               rd_data
);
    import ke_pkg::*;

    logic [width-1:0] mem [table_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < table_depth; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            // offset entries take only the low bits of the write data
            if (cfg.strobe && (cfg.sel == table_sel)) begin
                mem[cfg.index] <= cfg.data[width-1:0];
            end
            // old entry on a same-cycle write, new one from the next read
            if (rd_en) begin
                rd_data <= mem[rd_index];
            end
        end
    end

    // lookup result must survive a stall of the stage above
    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_en |=> $stable(rd_data));

endmodule

`default_nettype wire

/* src/ke_lookup_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ke_lookup_stage (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire ke_pkg::cfg_wr_t cfg,
    input  wire ke_pkg::phv_t    phv_in,
    input  wire logic            in_valid,
    output logic                 in_ready,
    output ke_pkg::phv_t         phv_out,
    output ke_pkg::key_offset_t  offset,
    output ke_pkg::key_t         mask,
    output logic                 out_valid,
    input  wire logic            out_ready
);
    import ke_pkg::*;

    logic accept;
    logic [tbl_aw-1:0] tenant;

    assign in_ready = !out_valid || out_ready;
    assign accept = in_valid && in_ready;
    assign tenant = phv_in.meta[tenant_lsb +: tbl_aw];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            phv_out <= '0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            if (accept) begin
                phv_out <= phv_in;
            end
        end
    end

    // reads start on the accept edge so entries line up with phv_out
    ke_config_table #(
        .width    (off_w),
        .table_sel(1'b0)
    ) u_offset_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .rd_en   (accept),
        .rd_index(tenant),
        .rd_data (offset)
    );

    ke_config_table #(
        .width    (key_w),
        .table_sel(1'b1)
    ) u_mask_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .rd_en   (accept),
        .rd_index(tenant),
        .rd_data (mask)
    );

    phv_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(phv_out));

endmodule

`default_nettype wire

/* src/ke_operand_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ke_operand_stage #(
    parameter int stage_id = 0
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ke_pkg::phv_t        phv_in,
    input  wire ke_pkg::key_offset_t offset_in,
    input  wire ke_pkg::key_t        mask_in,
    input  wire logic                in_valid,
    output logic                     in_ready,
    output ke_pkg::phv_t             phv_out,
    output ke_pkg::key_offset_t      offset_out,
    output ke_pkg::key_t             mask_out,
    output logic                     cmp_bit,
    output logic                     out_valid,
    input  wire logic                out_ready
);
    import ke_pkg::*;

    cmp_op_t op;
    logic [7:0] val_a;
    logic [7:0] val_b;
    logic cmp_res;
    op_bus_t stage_q;

    // low byte of the referenced container, or the literal
    function automatic logic [7:0] operand_value(operand_t opnd, phv_t phv);
        logic [7:0] v;
        v = '0;
        if (opnd.is_imm) begin
            v = opnd.val.imm;
        end else begin
            case (opnd.val.cref.width)
                sel_2b: v = phv.c2[opnd.val.cref.index][7:0];
                sel_4b: v = phv.c4[opnd.val.cref.index][7:0];
                sel_6b: v = phv.c6[opnd.val.cref.index][7:0];
                default: v = '0;
            endcase
        end
        return v;
    endfunction

    assign op = phv_in.ops[stage_id];
    assign val_a = operand_value(op.a, phv_in);
    assign val_b = operand_value(op.b, phv_in);

    always_comb begin
        case (op.code)
            cmp_gt: cmp_res = val_a > val_b;
            cmp_ge: cmp_res = val_a >= val_b;
            cmp_eq: cmp_res = val_a == val_b;
            default: cmp_res = 1'b1;
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            stage_q <= '0;
        end else if (in_ready) begin
            out_valid <= in_valid;
            if (in_valid) begin
                stage_q <= '{phv: phv_in, offset: offset_in, mask: mask_in, cmp_bit: cmp_res};
            end
        end
    end

    assign phv_out = stage_q.phv;
    assign offset_out = stage_q.offset;
    assign mask_out = stage_q.mask;
    assign cmp_bit = stage_q.cmp_bit;

    // nothing valid in the cycle that follows reset release
    no_early_valid: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid);

endmodule

`default_nettype wire

/* src/ke_key_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ke_key_stage #(
    parameter int stage_id = 0
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ke_pkg::phv_t        phv_in,
    input  wire ke_pkg::key_offset_t offset_in,
    input  wire ke_pkg::key_t        mask_in,
    input  wire logic                cmp_bit,
    input  wire logic                in_valid,
    output logic                     in_ready,
    output ke_pkg::phv_t             phv_out,
    output ke_pkg::key_t             key_out,
    output ke_pkg::key_t             key_mask_out,
    output logic                     out_valid,
    input  wire logic                out_ready
);
    import ke_pkg::*;

    key_t key_d;

    // two containers of each width, picked by the tenant offsets
    always_comb begin
        key_d = '0;
        key_d.c6_a = phv_in.c6[offset_in.c6_a];
        key_d.c6_b = phv_in.c6[offset_in.c6_b];
        key_d.c4_a = phv_in.c4[offset_in.c4_a];
        key_d.c4_b = phv_in.c4[offset_in.c4_b];
        key_d.c2_a = phv_in.c2[offset_in.c2_a];
        key_d.c2_b = phv_in.c2[offset_in.c2_b];
        // other stages' comparator bits stay zero
        key_d.cmp[n_stages-1-stage_id] = cmp_bit;
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            phv_out <= '0;
            key_out <= '0;
            key_mask_out <= '0;
        end else if (in_ready) begin
            out_valid <= in_valid;
            if (in_valid) begin
                phv_out <= phv_in;
                key_out <= key_d;
                key_mask_out <= mask_in;
            end
        end
    end

    key_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(key_out));

endmodule

`default_nettype wire

/* src/key_extract_top.sv */
`timescale 1ns/10ps
`default_nettype none

module key_extract_top #(
    parameter int stage_id = 0
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire ke_pkg::cfg_wr_t cfg,
    input  wire ke_pkg::phv_t    phv_in,
    input  wire logic            phv_valid_in,
    output logic                 ready_out,
    output ke_pkg::phv_t         phv_out,
    output ke_pkg::key_t         key_out,
    output ke_pkg::key_t         key_mask_out,
    output logic                 out_valid,
    input  wire logic            ready_in
);
    import ke_pkg::*;

    // lookup -> operand
    lk_bus_t s1;
    logic s1_valid;
    logic s1_ready;

    // operand -> key
    op_bus_t s2;
    logic s2_valid;
    logic s2_ready;

    ke_lookup_stage u_lookup (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .phv_in   (phv_in),
        .in_valid (phv_valid_in),
        .in_ready (ready_out),
        .phv_out  (s1.phv),
        .offset   (s1.offset),
        .mask     (s1.mask),
        .out_valid(s1_valid),
        .out_ready(s1_ready)
    );

    ke_operand_stage #(.stage_id(stage_id)) u_operand (
        .clk       (clk),
        .rst_n     (rst_n),
        .phv_in    (s1.phv),
        .offset_in (s1.offset),
        .mask_in   (s1.mask),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .phv_out   (s2.phv),
        .offset_out(s2.offset),
        .mask_out  (s2.mask),
        .cmp_bit   (s2.cmp_bit),
        .out_valid (s2_valid),
        .out_ready (s2_ready)
    );

    ke_key_stage #(.stage_id(stage_id)) u_key (
        .clk         (clk),
        .rst_n       (rst_n),
        .phv_in      (s2.phv),
        .offset_in   (s2.offset),
        .mask_in     (s2.mask),
        .cmp_bit     (s2.cmp_bit),
        .in_valid    (s2_valid),
        .in_ready    (s2_ready),
        .phv_out     (phv_out),
        .key_out     (key_out),
        .key_mask_out(key_mask_out),
        .out_valid   (out_valid),
        .out_ready   (ready_in)
    );

endmodule

`default_nettype wire

/* include/ke_tb_model.svh */
`ifndef KE_TB_MODEL_SVH
`define KE_TB_MODEL_SVH

// mirror of the tenant tables, updated with every cfg write
key_offset_t offset_mirror [table_depth];
key_t mask_mirror [table_depth];

function automatic logic [3:0] tenant_of(phv_t phv);
    return phv.meta[tenant_lsb +: 4];
endfunction

// flag at bit 8, then 3 spare bits, 2-bit width code and 3-bit index
function automatic logic [7:0] byte_of_operand(operand_t opnd, phv_t phv);
    logic [8:0] raw;
    logic [7:0] v;
    raw = opnd;
    v = 8'h00;
    if (raw[8]) begin
        v = raw[7:0];
    end else begin
        case (raw[4:3])
            2'b00: v = phv.c2[raw[2:0]][7:0];
            2'b01: v = phv.c4[raw[2:0]][7:0];
            2'b10: v = phv.c6[raw[2:0]][7:0];
            default: v = 8'h00;
        endcase
    end
    return v;
endfunction

function automatic logic compare_bytes(logic [1:0] code, logic [7:0] a, logic [7:0] b);
    logic res;
    case (code)
        2'b00: res = (a > b);
        2'b01: res = (a >= b);
        2'b10: res = (a == b);
        default: res = 1'b1;
    endcase
    return res;
endfunction

// stage 0 comparator lands in key bit 4, the rest stay zero
function automatic key_t expected_key(phv_t phv);
    key_offset_t off;
    cmp_op_t op;
    key_t k;
    off = offset_mirror[tenant_of(phv)];
    op = phv.ops[0];
    k = '0;
    k.c6_a = phv.c6[off.c6_a];
    k.c6_b = phv.c6[off.c6_b];
    k.c4_a = phv.c4[off.c4_a];
    k.c4_b = phv.c4[off.c4_b];
    k.c2_a = phv.c2[off.c2_a];
    k.c2_b = phv.c2[off.c2_b];
    k.cmp[4] = compare_bytes(op.code, byte_of_operand(op.a, phv), byte_of_operand(op.b, phv));
    return k;
endfunction

`endif

/* dv/tb_key_extract.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_key_extract;
    import ke_pkg::*;

    `include "ke_tb_model.svh"

    localparam int cw = $bits(phv_t);

    typedef struct packed {
        phv_t phv;
        key_t key;
        key_t mask;
        logic [31:0] acc_cyc;
    } exp_t;

    logic clk;
    logic rst_n;
    cfg_wr_t cfg;
    phv_t phv_in;
    logic phv_valid_in;
    logic ready_out;
    phv_t phv_out;
    key_t key_out;
    key_t key_mask_out;
    logic out_valid;
    logic ready_in;

    logic [31:0] rng_state;
    exp_t exp_q[$];
    int n_tests;
    int n_checks;
    int n_errors;
    int test_errors;

    key_extract_top #(.stage_id(0)) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .phv_in      (phv_in),
        .phv_valid_in(phv_valid_in),
        .ready_out   (ready_out),
        .phv_out     (phv_out),
        .key_out     (key_out),
        .key_mask_out(key_mask_out),
        .out_valid   (out_valid),
        .ready_in    (ready_in)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // lcg, output folded so the low bits are usable
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 15);
    endfunction

    function automatic phv_t rand_phv();
        logic [36*32-1:0] raw;
        for (int i = 0; i < 36; i++) begin
            raw[i*32 +: 32] = next_rand();
        end
        return raw[cw-1:0];
    endfunction

    function automatic logic [key_w-1:0] rand_entry();
        logic [7*32-1:0] raw;
        for (int i = 0; i < 7; i++) begin
            raw[i*32 +: 32] = next_rand();
        end
        return raw[key_w-1:0];
    endfunction

    task automatic check_value(input string name, input logic [cw-1:0] got,
                               input logic [cw-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic close_test(input string name);
        n_tests++;
        $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    // one table entry per call, mirrored in the model
    task automatic write_entry(input logic sel, input logic [3:0] idx,
                               input logic [key_w-1:0] data);
        @(negedge clk);
        cfg.strobe = 1'b1;
        cfg.sel = sel;
        cfg.index = idx;
        cfg.data = data;
        if (sel) begin
            mask_mirror[idx] = data;
        end else begin
            offset_mirror[idx] = data[off_w-1:0];
        end
        @(negedge clk);
        cfg.strobe = 1'b0;
    endtask

    task automatic load_tables();
        for (int i = 0; i < table_depth; i++) begin
            write_entry(1'b0, i[3:0], rand_entry());
            write_entry(1'b1, i[3:0], rand_entry());
        end
        close_test("table load");
    endtask

    // drive n_phv PHVs and check every output transfer against the queue
    task automatic run_traffic(input string name, input int n_phv, input bit stall,
                               input bit lat_check);
        int sent;
        int cycles;
        int stall_run;
        int full_cycles;
        logic [31:0] r;
        logic taken;
        logic held;
        exp_t snap;
        exp_t e;
        sent = 0;
        cycles = 0;
        stall_run = 0;
        full_cycles = 0;
        taken = 1'b0;
        held = 1'b0;
        snap = '0;
        while ((sent < n_phv || exp_q.size() > 0 || phv_valid_in) && cycles < 5000) begin
            @(negedge clk);
            cycles++;
            r = next_rand();
            // a PHV not yet taken stays on the bus
            if (!phv_valid_in || taken) begin
                phv_valid_in = 1'b0;
                if (sent < n_phv && (!stall || r[3:0] > 4'd4)) begin
                    phv_in = rand_phv();
                    phv_valid_in = 1'b1;
                end
            end
            if (!stall) begin
                ready_in = 1'b1;
            end else if (stall_run > 0) begin
                ready_in = 1'b0;
                stall_run--;
            end else if (r[31:27] == 5'd0) begin
                ready_in = 1'b0;
                stall_run = 10 + int'(r[26:23]);
            end else begin
                ready_in = r[20] | r[21];
            end
            #1;
            taken = phv_valid_in && ready_out;
            if (taken) begin
                e.phv = phv_in;
                e.key = expected_key(phv_in);
                e.mask = mask_mirror[tenant_of(phv_in)];
                e.acc_cyc = cycles;
                exp_q.push_back(e);
                sent++;
            end
            if (held) begin
                check_value("out_valid", out_valid, 1'b1);
                check_value("phv_out", phv_out, snap.phv);
                check_value("key_out", key_out, snap.key);
                check_value("key_mask_out", key_mask_out, snap.mask);
            end
            held = out_valid && !ready_in;
            snap.phv = phv_out;
            snap.key = key_out;
            snap.mask = key_mask_out;
            if (out_valid && ready_in) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    test_errors++;
                    $display("output transfer at %0t with no PHV in flight", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("phv_out", phv_out, e.phv);
                    check_value("key_out", key_out, e.key);
                    check_value("key_out.cmp", key_out.cmp, e.key.cmp);
                    check_value("key_mask_out", key_mask_out, e.mask);
                    if (lat_check) begin
                        check_value("latency", cycles - int'(e.acc_cyc), 3);
                    end
                end
            end
            if (!ready_out) begin
                full_cycles++;
            end
        end
        if (cycles >= 5000) begin
            n_errors++;
            test_errors++;
            $display("timeout in test %s: %0d of %0d PHVs sent, %0d still in flight",
                     name, sent, n_phv, exp_q.size());
            exp_q.delete();
            phv_valid_in = 1'b0;
        end
        if (stall && full_cycles == 0) begin
            n_errors++;
            test_errors++;
            $display("ready_out never fell in test %s although output was stalled", name);
        end
        if (!stall && full_cycles != 0) begin
            n_errors++;
            test_errors++;
            $display("ready_out fell in test %s without any output stall", name);
        end
        close_test(name);
    endtask

    initial begin
        logic [3:0] t;
        rng_state = 32'h3397;
        rst_n = 1'b0;
        cfg = '0;
        phv_in = '0;
        phv_valid_in = 1'b0;
        ready_in = 1'b0;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
        test_errors = 0;
        for (int i = 0; i < table_depth; i++) begin
            offset_mirror[i] = '0;
            mask_mirror[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #1;
        check_value("out_valid", out_valid, 1'b0);
        check_value("ready_out", ready_out, 1'b1);
        close_test("reset");

        // tables still hold their reset value here
        run_traffic("empty tables", 8, 1'b0, 1'b1);
        load_tables();
        run_traffic("stream", 96, 1'b0, 1'b1);
        run_traffic("backpressure", 240, 1'b1, 1'b0);

        t = next_rand() % 16;
        write_entry(1'b0, t, rand_entry());
        write_entry(1'b1, t, rand_entry());
        run_traffic("tenant rewrite", 96, 1'b1, 1'b0);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/ke_pkg.sv
src/ke_config_table.sv
src/ke_lookup_stage.sv
src/ke_operand_stage.sv
src/ke_key_stage.sv
src/key_extract_top.sv
dv/tb_key_extract.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the key extraction testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_key_extract -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
